/* verilog/tlmem_pkg.sv */
package tlmem_pkg;

    // TL-UL bus widths
    localparam int AddrW   = 32;
    localparam int DataW   = 32;
    localparam int MaskW   = 4;
    localparam int SourceW = 4;
    localparam int OpW     = 3;                   // Both A and D opcodes
    localparam int ByteW   = DataW / MaskW;

    // Bank geometry
    localparam int BankAw     = 8;                // 256 words per bank
    localparam int BankSelBit = 2;                // Even/odd word interleave
    localparam int TopAddrBit = 10;               // 2 KB window

    // Outstanding requests
    localparam int MaxInflight = 2;
    localparam int CntW        = $clog2(MaxInflight + 1);
    localparam int PtrW        = $clog2(MaxInflight);

    localparam logic [MaskW-1:0] FullMask = {MaskW{1'b1}};

    // A-channel opcodes in TL-UL encoding
    typedef enum logic [OpW-1:0] {
        PutFullData    = 3'h0,
        PutPartialData = 3'h1,
        Get            = 3'h4
    } a_opcode_e;

    // D-channel opcodes
    typedef enum logic [OpW-1:0] {
        AccessAck     = 3'h0,
        AccessAckData = 3'h1
    } d_opcode_e;

endpackage

/* verilog/sram_if.sv */
interface sram_if;

    logic                               req;      // One-cycle strobe
    logic                               we;
    logic [tlmem_pkg::BankAw-1:0]       addr;     // Word address in bank
    logic [tlmem_pkg::DataW-1:0]        wdata;
    logic [tlmem_pkg::MaskW-1:0]        wmask;    // Byte enables
    logic [tlmem_pkg::DataW-1:0]        rdata;
    logic                               rvalid;   // Cycle after read strobe

    modport host (
        output req, we, addr, wdata, wmask
    );

    modport bank (
        input  req, we, addr, wdata, wmask,
        output rdata, rvalid
    );

    modport reader (
        input rdata, rvalid
    );

endinterface

/* verilog/rsp_meta_if.sv */
interface rsp_meta_if;

    logic                           valid;        // Pulses once per accept
    logic                           is_read;      // Set for every Get
    logic [tlmem_pkg::SourceW-1:0]  source;
    logic                           error;
    logic                           bank;         // Odd bank when set

    modport src (
        output valid, is_read, source, error, bank
    );

    modport dst (
        input valid, is_read, source, error, bank
    );

endinterface

/* verilog/tlul_req_decode.sv */
module tlul_req_decode (
    input  logic                            clk_i,
    input  logic                            rst_ni,

    input  logic                            a_valid_i,
    input  logic [tlmem_pkg::OpW-1:0]       a_opcode_i,
    input  logic [tlmem_pkg::AddrW-1:0]     a_address_i,
    input  logic [tlmem_pkg::DataW-1:0]     a_data_i,
    input  logic [tlmem_pkg::MaskW-1:0]     a_mask_i,
    input  logic [tlmem_pkg::SourceW-1:0]   a_source_i,
    output logic                            a_ready_o,

    input  logic                            retire_i,

    sram_if.host                            bank0_o,
    sram_if.host                            bank1_o,
    rsp_meta_if.src                         meta_o
);

    logic [tlmem_pkg::CntW-1:0]     credit_q;
    logic                           accept;
    logic                           is_get;
    logic                           op_known;
    logic                           addr_err;
    logic                           mask_err;
    logic                           req_err;
    logic                           bank_sel;
    logic [tlmem_pkg::BankAw-1:0]   word_addr;
    logic [tlmem_pkg::MaskW-1:0]    byte_mask;

    assign a_ready_o = (credit_q != tlmem_pkg::CntW'(tlmem_pkg::MaxInflight));
    assign accept    = a_valid_i && a_ready_o;

    // Request classification
    assign is_get   = (a_opcode_i == tlmem_pkg::Get);
    assign op_known = is_get || (a_opcode_i == tlmem_pkg::PutFullData) ||
                      (a_opcode_i == tlmem_pkg::PutPartialData);
    assign addr_err = |a_address_i[tlmem_pkg::AddrW-1:tlmem_pkg::TopAddrBit+1];
    assign mask_err = (a_opcode_i == tlmem_pkg::PutFullData) &&
                      (a_mask_i != tlmem_pkg::FullMask);
    assign req_err  = addr_err || !op_known || mask_err;

    assign bank_sel  = a_address_i[tlmem_pkg::BankSelBit];
    assign word_addr = a_address_i[tlmem_pkg::TopAddrBit:tlmem_pkg::BankSelBit+1];
    assign byte_mask = is_get ? tlmem_pkg::FullMask : a_mask_i;  // Reads fetch the whole word

    // Erroneous requests stay off the banks
    assign bank0_o.req   = accept && !req_err && !bank_sel;
    assign bank0_o.we    = !is_get;
    assign bank0_o.addr  = word_addr;
    assign bank0_o.wdata = a_data_i;
    assign bank0_o.wmask = byte_mask;

    assign bank1_o.req   = accept && !req_err && bank_sel;
    assign bank1_o.we    = !is_get;
    assign bank1_o.addr  = word_addr;
    assign bank1_o.wdata = a_data_i;
    assign bank1_o.wmask = byte_mask;

    // Metadata for the merger in the strobe cycle
    assign meta_o.valid   = accept;
    assign meta_o.is_read = is_get;
    assign meta_o.source  = a_source_i;
    assign meta_o.error   = req_err;
    assign meta_o.bank    = bank_sel;

    // Requests accepted but not yet retired on D
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            credit_q <= '0;
        end else if (accept && !retire_i) begin
            credit_q <= credit_q + tlmem_pkg::CntW'(1);
        end else if (!accept && retire_i) begin
            credit_q <= credit_q - tlmem_pkg::CntW'(1);
        end
    end

    a_credit_bound: assert property (@(posedge clk_i) disable iff (!rst_ni)
        credit_q <= tlmem_pkg::CntW'(tlmem_pkg::MaxInflight));

    a_retire_owed: assert property (@(posedge clk_i) disable iff (!rst_ni)
        retire_i |-> (credit_q != '0));

endmodule

/* verilog/sram_bank.sv */
module sram_bank (
    input  logic    clk_i,
    input  logic    rst_ni,
    sram_if.bank    mem_io
);

    localparam int Depth = 2 ** tlmem_pkg::BankAw;

    logic [tlmem_pkg::DataW-1:0]    mem_q [Depth];    // Behavioral array
    logic [tlmem_pkg::DataW-1:0]    rdata_q;
    logic                           rvalid_q;

    // Write lands at the end of the strobe cycle
    always_ff @(posedge clk_i) begin
        if (mem_io.req) begin
            if (mem_io.we) begin
                for (int b = 0; b < tlmem_pkg::MaskW; b++) begin
                    if (mem_io.wmask[b]) begin
                        mem_q[mem_io.addr][b*tlmem_pkg::ByteW +: tlmem_pkg::ByteW] <=
                            mem_io.wdata[b*tlmem_pkg::ByteW +: tlmem_pkg::ByteW];
                    end
                end
            end else begin
                rdata_q <= mem_q[mem_io.addr];              // Registered read
            end
        end
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            rvalid_q <= 1'b0;
        end else begin
            rvalid_q <= mem_io.req && !mem_io.we;
        end
    end

    assign mem_io.rdata  = rdata_q;
    assign mem_io.rvalid = rvalid_q;

    a_addr_known: assert property (@(posedge clk_i) disable iff (!rst_ni)
        mem_io.req |-> !$isunknown(mem_io.addr));

endmodule

/* verilog/tlul_rsp_merge.sv */
module tlul_rsp_merge (
    input  logic                            clk_i,
    input  logic                            rst_ni,

    rsp_meta_if.dst                         meta_i,
    sram_if.reader                          bank0_i,
    sram_if.reader                          bank1_i,

    input  logic                            d_ready_i,
    output logic                            d_valid_o,
    output logic [tlmem_pkg::OpW-1:0]       d_opcode_o,
    output logic [tlmem_pkg::DataW-1:0]     d_data_o,
    output logic [tlmem_pkg::SourceW-1:0]   d_source_o,
    output logic                            d_error_o,
    output logic                            retire_o
);

    // Metadata delayed to meet the bank read data
    logic                               meta_valid_q;
    logic                               is_read_q;
    logic [tlmem_pkg::SourceW-1:0]      source_q;
    logic                               error_q;
    logic                               bank_q;

    logic                               push;
    logic                               pop;
    tlmem_pkg::d_opcode_e               rsp_opcode;
    logic [tlmem_pkg::DataW-1:0]        rsp_data;

    // Response FIFO
    tlmem_pkg::d_opcode_e               fifo_op_q  [tlmem_pkg::MaxInflight];
    logic [tlmem_pkg::DataW-1:0]        fifo_data_q[tlmem_pkg::MaxInflight];
    logic [tlmem_pkg::SourceW-1:0]      fifo_src_q [tlmem_pkg::MaxInflight];
    logic                               fifo_err_q [tlmem_pkg::MaxInflight];
    logic [tlmem_pkg::PtrW-1:0]         wr_ptr_q;
    logic [tlmem_pkg::PtrW-1:0]         rd_ptr_q;
    logic [tlmem_pkg::CntW-1:0]         count_q;

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            meta_valid_q <= 1'b0;
        end else begin
            meta_valid_q <= meta_i.valid;
        end
    end

    always_ff @(posedge clk_i) begin
        is_read_q <= meta_i.is_read;
        source_q  <= meta_i.source;
        error_q   <= meta_i.error;
        bank_q    <= meta_i.bank;
    end

    // Errors keep the opcode class but carry no data
    assign rsp_opcode = is_read_q ? tlmem_pkg::AccessAckData : tlmem_pkg::AccessAck;
    assign rsp_data   = (is_read_q && !error_q) ? (bank_q ? bank1_i.rdata : bank0_i.rdata)
                                                : '0;

    assign push = meta_valid_q;
    assign pop  = d_valid_o && d_ready_i;

    always_ff @(posedge clk_i) begin
        if (push) begin
            fifo_op_q[wr_ptr_q]   <= rsp_opcode;
            fifo_data_q[wr_ptr_q] <= rsp_data;
            fifo_src_q[wr_ptr_q]  <= source_q;
            fifo_err_q[wr_ptr_q]  <= error_q;
        end
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (push) wr_ptr_q <= wr_ptr_q + tlmem_pkg::PtrW'(1);
            if (pop) rd_ptr_q <= rd_ptr_q + tlmem_pkg::PtrW'(1);
            if (push && !pop) begin
                count_q <= count_q + tlmem_pkg::CntW'(1);
            end else if (pop && !push) begin
                count_q <= count_q - tlmem_pkg::CntW'(1);
            end
        end
    end

    assign d_valid_o  = (count_q != '0);
    assign d_opcode_o = fifo_op_q[rd_ptr_q];
    assign d_data_o   = fifo_data_q[rd_ptr_q];
    assign d_source_o = fifo_src_q[rd_ptr_q];
    assign d_error_o  = fifo_err_q[rd_ptr_q];
    assign retire_o   = pop;                              // Frees a decoder credit

    a_single_rvalid: assert property (@(posedge clk_i) disable iff (!rst_ni)
        !(bank0_i.rvalid && bank1_i.rvalid));

    a_rvalid_meta: assert property (@(posedge clk_i) disable iff (!rst_ni)
        (bank0_i.rvalid || bank1_i.rvalid) == (meta_valid_q && is_read_q && !error_q));

    a_no_overflow: assert property (@(posedge clk_i) disable iff (!rst_ni)
        push |-> (count_q != tlmem_pkg::CntW'(tlmem_pkg::MaxInflight)));

endmodule

/* verilog/tlmem_top.sv */
module tlmem_top (
    input  logic                            clk_i,
    input  logic                            rst_ni,

    // A channel
    input  logic                            a_valid_i,
    output logic                            a_ready_o,
    input  logic [tlmem_pkg::OpW-1:0]       a_opcode_i,
    input  logic [tlmem_pkg::AddrW-1:0]     a_address_i,
    input  logic [tlmem_pkg::DataW-1:0]     a_data_i,
    input  logic [tlmem_pkg::MaskW-1:0]     a_mask_i,
    input  logic [tlmem_pkg::SourceW-1:0]   a_source_i,

    // D channel
    output logic                            d_valid_o,
    input  logic                            d_ready_i,
    output logic [tlmem_pkg::OpW-1:0]       d_opcode_o,
    output logic [tlmem_pkg::DataW-1:0]     d_data_o,
    output logic [tlmem_pkg::SourceW-1:0]   d_source_o,
    output logic                            d_error_o
);

    logic retire;

    sram_if     bank0_if ();                  // Even words
    sram_if     bank1_if ();                  // Odd words
    rsp_meta_if meta_if ();

    tlul_req_decode u_decode (
        .clk_i       (clk_i      ),
        .rst_ni      (rst_ni     ),
        .a_valid_i   (a_valid_i  ),
        .a_opcode_i  (a_opcode_i ),
        .a_address_i (a_address_i),
        .a_data_i    (a_data_i   ),
        .a_mask_i    (a_mask_i   ),
        .a_source_i  (a_source_i ),
        .a_ready_o   (a_ready_o  ),
        .retire_i    (retire     ),
        .bank0_o     (bank0_if   ),
        .bank1_o     (bank1_if   ),
        .meta_o      (meta_if    )
    );

    sram_bank u_bank0 (
        .clk_i  (clk_i   ),
        .rst_ni (rst_ni  ),
        .mem_io (bank0_if)
    );

    sram_bank u_bank1 (
        .clk_i  (clk_i   ),
        .rst_ni (rst_ni  ),
        .mem_io (bank1_if)
    );

    tlul_rsp_merge u_merge (
        .clk_i      (clk_i     ),
        .rst_ni     (rst_ni    ),
        .meta_i     (meta_if   ),
        .bank0_i    (bank0_if  ),
        .bank1_i    (bank1_if  ),
        .d_ready_i  (d_ready_i ),
        .d_valid_o  (d_valid_o ),
        .d_opcode_o (d_opcode_o),
        .d_data_o   (d_data_o  ),
        .d_source_o (d_source_o),
        .d_error_o  (d_error_o ),
        .retire_o   (retire    )
    );

endmodule

/* bench/tb_tlmem.sv */
module tb_tlmem;

    localparam int FillWords     = 32;                   // Words preloaded by the first test
    localparam int RandReqs      = 200;
    localparam int TestCycles    = 4 * 2 * FillWords + 200 + 8 * RandReqs;
    localparam int TimeoutCycles = 2 * TestCycles;       // About 4000 cycles
    localparam int ReadyWait     = 64;                   // Longer than this counts as stuck
    localparam int ModelWords    = 2 ** (tlmem_pkg::TopAddrBit - 1);

    logic                               clk_i;
    logic                               rst_ni;
    logic                               a_valid_i;
    logic                               a_ready_o;
    logic [tlmem_pkg::OpW-1:0]          a_opcode_i;
    logic [tlmem_pkg::AddrW-1:0]        a_address_i;
    logic [tlmem_pkg::DataW-1:0]        a_data_i;
    logic [tlmem_pkg::MaskW-1:0]        a_mask_i;
    logic [tlmem_pkg::SourceW-1:0]      a_source_i;
    logic                               d_valid_o;
    logic                               d_ready_i;
    logic [tlmem_pkg::OpW-1:0]          d_opcode_o;
    logic [tlmem_pkg::DataW-1:0]        d_data_o;
    logic [tlmem_pkg::SourceW-1:0]      d_source_o;
    logic                               d_error_o;

    logic [tlmem_pkg::DataW-1:0]        model [ModelWords];   // Reference memory
    logic [tlmem_pkg::OpW-1:0]          exp_op [512];         // Expected responses, in order
    logic [tlmem_pkg::DataW-1:0]        exp_data [512];
    logic [tlmem_pkg::SourceW-1:0]      exp_src [512];
    logic                               exp_err [512];
    int                                 wr_idx = 0;
    int                                 rd_idx = 0;
    logic [15:0]                        lfsr_q;
    logic                               rand_ready;           // Random d_ready_i when set
    int                                 errors = 0;
    int                                 checks = 0;
    int                                 mon_errors = 0;
    int                                 mon_checks = 0;
    int                                 cycles = 0;

    tlmem_top i_tlmem_top (.*);

    initial clk_i = 1'b0;
    always #5 clk_i = ~clk_i;

    always @(posedge clk_i) begin
        cycles <= cycles + 1;
        if (cycles >= TimeoutCycles) begin
            $display("Timeout after %0d cycles, the tests did not finish", cycles);
            $display("TEST FAILED");
            $finish;
        end
    end

    // Compares every D-channel transfer with the expected queue
    always @(posedge clk_i) begin
        if (rst_ni && d_valid_o && d_ready_i) begin
            if (rd_idx == wr_idx) begin
                mon_errors <= mon_errors + 1;
                $display("Unexpected response with source %0d at %0t", d_source_o, $time);
            end else begin
                mon_checks <= mon_checks + 1;
                if (d_opcode_o !== exp_op[rd_idx] || d_data_o !== exp_data[rd_idx] ||
                    d_source_o !== exp_src[rd_idx] || d_error_o !== exp_err[rd_idx]) begin
                    mon_errors <= mon_errors + 1;
                    $display("Mismatch at %0t: got op %0d data %h src %0d err %b", $time,
                             d_opcode_o, d_data_o, d_source_o, d_error_o);
                    $display("    expected op %0d data %h src %0d err %b", exp_op[rd_idx],
                             exp_data[rd_idx], exp_src[rd_idx], exp_err[rd_idx]);
                end
                rd_idx <= rd_idx + 1;
            end
        end
    end

    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);    // x^16 + x^14 + x^13 + x^11 + 1
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int k = 0; k < n; k++) begin
            v = {v[30:0], lfsr_q[0]};
            lfsr_q = lfsr_next(lfsr_q);
        end
        return v;
    endfunction

    function automatic logic [31:0] fill_word(input logic [31:0] addr);
        return (addr * 32'h9E37_79B9) ^ {addr[15:0], addr[31:16]} ^ 32'hC3A5_5A3C;
    endfunction

    // Drives one A-channel request and records the response it must produce
    task automatic send(input logic [2:0] op, input logic [31:0] addr,
                        input logic [31:0] data, input logic [3:0] mask, input logic [3:0] src);
        int         waited;
        logic       is_get;
        logic       err;
        logic [8:0] idx;
        waited      = 0;
        a_valid_i   = 1'b1;
        a_opcode_i  = op;
        a_address_i = addr;
        a_data_i    = data;
        a_mask_i    = mask;
        a_source_i  = src;
        if (rand_ready) d_ready_i = (rand_bits(2) != 32'd0);
        while (!a_ready_o && waited < ReadyWait) begin
            @(negedge clk_i);
            waited++;
            if (rand_ready) d_ready_i = (rand_bits(2) != 32'd0);
        end
        checks++;
        if (!a_ready_o) begin
            errors++;
            $display("a_ready_o stuck low for %0d cycles at %0t", waited, $time);
            a_valid_i = 1'b0;
        end else begin
            is_get = (op == tlmem_pkg::Get);
            err = (|addr[tlmem_pkg::AddrW-1:tlmem_pkg::TopAddrBit+1]) ||
                  !(is_get || op == tlmem_pkg::PutFullData || op == tlmem_pkg::PutPartialData) ||
                  (op == tlmem_pkg::PutFullData && mask != 4'hF);
            idx = addr[tlmem_pkg::TopAddrBit:2];
            exp_op[wr_idx]   = is_get ? tlmem_pkg::AccessAckData : tlmem_pkg::AccessAck;
            exp_data[wr_idx] = (is_get && !err) ? model[idx] : 32'h0;
            exp_src[wr_idx]  = src;
            exp_err[wr_idx]  = err;
            wr_idx++;
            if (!is_get && !err) begin
                for (int b = 0; b < 4; b++) begin
                    if (mask[b]) model[idx][b*8 +: 8] = data[b*8 +: 8];
                end
            end
            @(posedge clk_i);                            // Transfer edge
            @(negedge clk_i);
            a_valid_i = 1'b0;
        end
    endtask

    task automatic wait_drain();
        int waited;
        waited = 0;
        while (rd_idx != wr_idx && waited < 50) begin
            @(negedge clk_i);
            waited++;
        end
        checks++;
        if (rd_idx != wr_idx) begin
            errors++;
            $display("%0d response(s) never arrived by %0t", wr_idx - rd_idx, $time);
        end
    endtask

    task automatic fill_and_read();
        for (int i = 0; i < FillWords; i++) begin
            send(tlmem_pkg::PutFullData, 32'(i * 4), fill_word(32'(i * 4)), 4'hF, 4'(i));
        end
        for (int i = 0; i < FillWords; i++) begin
            send(tlmem_pkg::Get, 32'(i * 4), 32'h0, 4'h0, 4'(i + 3));
        end
        wait_drain();
    endtask

    task automatic partial_writes();
        send(tlmem_pkg::PutPartialData, 32'h00, 32'h1122_3344, 4'b0001, 4'h1);
        send(tlmem_pkg::PutPartialData, 32'h04, 32'h5566_7788, 4'b0110, 4'h2);
        send(tlmem_pkg::PutPartialData, 32'h08, 32'h99AA_BBCC, 4'b1000, 4'h3);
        send(tlmem_pkg::PutPartialData, 32'h0C, 32'hDDEE_FF00, 4'b1010, 4'h4);
        send(tlmem_pkg::PutPartialData, 32'h10, 32'hFFFF_FFFF, 4'b0000, 4'h5);
        for (int i = 0; i < 5; i++) begin
            send(tlmem_pkg::Get, 32'(i * 4), 32'h0, 4'hF, 4'(i + 8));
        end
        wait_drain();
    endtask

    task automatic error_cases();
        send(tlmem_pkg::Get, 32'h0000_0800, 32'h0, 4'hF, 4'h1);            // Bit 11 set
        send(tlmem_pkg::PutFullData, 32'h0000_1004, 32'hBAD0_0001, 4'hF, 4'h2);
        send(3'h2, 32'h0000_0008, 32'hBAD0_0002, 4'hF, 4'h3);              // Unsupported opcode
        send(tlmem_pkg::PutFullData, 32'h0000_000C, 32'hBAD0_0003, 4'b0111, 4'h4);
        send(tlmem_pkg::Get, 32'h04, 32'h0, 4'hF, 4'h5);                   // Words stay intact
        send(tlmem_pkg::Get, 32'h08, 32'h0, 4'hF, 4'h6);
        send(tlmem_pkg::Get, 32'h0C, 32'h0, 4'hF, 4'h7);
        wait_drain();
    endtask

    task automatic backpressure();
        d_ready_i = 1'b0;
        send(tlmem_pkg::Get, 32'h00, 32'h0, 4'hF, 4'hA);
        send(tlmem_pkg::PutFullData, 32'h14, 32'hCAFE_F00D, 4'hF, 4'hB);
        repeat (4) begin
            checks++;
            if (a_ready_o || !d_valid_o) begin
                errors++;
                $display("a_ready_o not held low with two requests in flight at %0t", $time);
            end
            @(negedge clk_i);
        end
        d_ready_i = 1'b1;
        send(tlmem_pkg::Get, 32'h14, 32'h0, 4'hF, 4'hC);
        wait_drain();
    endtask

    task automatic random_traffic();
        logic [1:0]  sel;
        logic [2:0]  op;
        logic [31:0] addr;
        logic [4:0]  hi;
        logic [3:0]  mask;
        rand_ready = 1'b1;
        for (int i = 0; i < RandReqs; i++) begin
            sel  = 2'(rand_bits(2));
            op   = (sel == 2'd2) ? tlmem_pkg::PutFullData :
                   (sel == 2'd3) ? tlmem_pkg::PutPartialData : tlmem_pkg::Get;
            addr = rand_bits(5) << 2;                     // Inside the preloaded words
            if (rand_bits(3) == 32'd0) begin
                hi       = 5'(11 + rand_bits(4));         // Out of the 2 KB window
                addr[hi] = 1'b1;
            end
            mask = 4'(rand_bits(4));
            if (op == tlmem_pkg::PutFullData && rand_bits(1) == 32'd1) mask = 4'hF;
            send(op, addr, rand_bits(32), mask, 4'(i));
        end
        rand_ready = 1'b0;
        d_ready_i  = 1'b1;
        wait_drain();
    endtask

    initial begin
        rst_ni      = 1'b0;
        a_valid_i   = 1'b0;
        a_opcode_i  = '0;
        a_address_i = '0;
        a_data_i    = '0;
        a_mask_i    = '0;
        a_source_i  = '0;
        d_ready_i   = 1'b1;
        lfsr_q      = 16'd34;
        rand_ready  = 1'b0;
        repeat (8) @(posedge clk_i);
        @(negedge clk_i);
        rst_ni = 1'b1;
        checks++;
        if (!a_ready_o || d_valid_o) begin
            errors++;
            $display("Handshake outputs wrong after reset at %0t", $time);
        end
        fill_and_read();
        partial_writes();
        error_cases();
        backpressure();
        random_traffic();
        $display("Checks: %0d, errors: %0d", checks + mon_checks, errors + mon_errors);
        if (errors + mon_errors == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

/* sim.f */
verilog/tlmem_pkg.sv
verilog/sram_if.sv
verilog/rsp_meta_if.sv
verilog/tlul_req_decode.sv
verilog/sram_bank.sv
verilog/tlul_rsp_merge.sv
verilog/tlmem_top.sv
bench/tb_tlmem.sv

/* run.sh */
#!/bin/sh
# Builds the TL-UL memory testbench with Verilator and runs it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module tb_tlmem -Mdir obj_dir -o tb_tlmem -f sim.f
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

sim_out=$(./obj_dir/tb_tlmem)
sim_status=$?
echo "$sim_out"
if [ $sim_status -ne 0 ]; then
    echo "Simulation exited with status $sim_status"
    exit 1
fi

if echo "$sim_out" | grep -qx "TEST PASSED"; then
    exit 0
fi
echo "Pass message not found"
exit 1
